// ==== Makefile ====
SIM      ?= verilator
SIMFLAGS ?= --binary --timing --assert -Wno-fatal
TOP      ?= tb_frame_dump
FLIST    ?= tb.f
OBJDIR   ?= obj_dir
PASS_MSG := Verification passed

.PHONY: sim clean

sim:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)
	out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// ==== hdl/capture_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module capture_ctrl (
    input  logic                    mainclk,
    input  logic                    rst,
    input  logic                    arm,
    input  logic                    eth_rx_dv,
    input  logic                    dump_done,
    output capture_pkg::cap_state_t state,
    output logic                    rec_en,
    output logic                    frame_start,
    output logic                    dump_start
);
    import capture_pkg::*;

    // transition strobes, decoded from the current state
    always_comb begin
        // armed and a frame begins
        frame_start = (state == CAP_IDLE) && arm && eth_rx_dv;
        // frame over, start the dump
        dump_start  = (state == CAP_REC) && !eth_rx_dv;
        // capture window
        rec_en      = (state == CAP_REC);
    end

    // idle -> rec -> dump -> idle
    // nibble on the idle exit cycle is not captured
    always_ff @(posedge mainclk) begin
        if (rst) begin
            state <= CAP_IDLE;
        end else begin
            unique case (state)
                CAP_IDLE: begin
                    if (frame_start) begin
                        state <= CAP_REC;
                    end
                end
                CAP_REC: begin
                    if (dump_start) begin
                        state <= CAP_DUMP;
                    end
                end
                CAP_DUMP: begin
                    // dumper finished, wait for next frame
                    if (dump_done) begin
                        state <= CAP_IDLE;
                    end
                end
                default: begin
                    state <= CAP_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/capture_pkg.sv ====
`default_nettype none

`include "capture_macros.svh"

package capture_pkg;

    // top level sequence, also the status output
    typedef enum logic [1:0] {
        CAP_IDLE = 2'd0,
        CAP_REC  = 2'd1,
        CAP_DUMP = 2'd2
    } cap_state_t;

    // one stored word
    typedef logic [`CAP_WORD_W-1:0] word_t;

    // ram address
    typedef logic [`CAP_ADDR_W-1:0] addr_t;

    // word count, one extra bit so a full ram is representable
    typedef logic [`CAP_ADDR_W:0] count_t;

    // one serial byte
    typedef logic [7:0] ascii_t;

    // write request into the frame ram
    typedef struct packed {
        logic  en;
        addr_t addr;
        word_t data;
    } ram_wr_t;

    // read request, data comes back a cycle later
    typedef struct packed {
        logic  en;
        addr_t addr;
    } ram_rd_t;

endpackage

`default_nettype wire

// ==== hdl/frame_dump_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_dump_top (
    input  logic                    mainclk,
    input  logic                    rst,
    input  logic                    arm,
    input  logic                    eth_rx_dv,
    input  logic [3:0]              eth_rxd,
    output logic                    uart_txd,
    output capture_pkg::cap_state_t state
);
    import capture_pkg::*;

    // sequencing strobes
    logic    frame_start;
    logic    rec_en;
    logic    dump_start;
    logic    dump_done;

    // ram side
    ram_wr_t wr;
    ram_rd_t rd;
    word_t   rd_data;
    count_t  word_count;

    // dumper to uart
    ascii_t  tx_data;
    logic    tx_valid;
    logic    tx_ready;

    capture_ctrl u_capture_ctrl (
        .mainclk     (mainclk),
        .rst         (rst),
        .arm         (arm),
        .eth_rx_dv   (eth_rx_dv),
        .dump_done   (dump_done),
        .state       (state),
        .rec_en      (rec_en),
        .frame_start (frame_start),
        .dump_start  (dump_start)
    );

    nibble_packer u_nibble_packer (
        .mainclk     (mainclk),
        .rst         (rst),
        .frame_start (frame_start),
        .rec_en      (rec_en),
        .eth_rx_dv   (eth_rx_dv),
        .eth_rxd     (eth_rxd),
        .wr          (wr),
        .word_count  (word_count)
    );

    frame_ram u_frame_ram (
        .mainclk (mainclk),
        .wr      (wr),
        .rd      (rd),
        .rd_data (rd_data)
    );

    hex_dumper u_hex_dumper (
        .mainclk    (mainclk),
        .rst        (rst),
        .dump_start (dump_start),
        .word_count (word_count),
        .rd         (rd),
        .rd_data    (rd_data),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .dump_done  (dump_done)
    );

    uart_tx u_uart_tx (
        .mainclk  (mainclk),
        .rst      (rst),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .txd      (uart_txd)
    );

endmodule

`default_nettype wire

// ==== hdl/frame_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "capture_macros.svh"

module frame_ram (
    input  logic                  mainclk,
    input  capture_pkg::ram_wr_t  wr,
    input  capture_pkg::ram_rd_t  rd,
    output capture_pkg::word_t    rd_data
);
    import capture_pkg::*;

    // plain register array
    word_t mem [`CAP_DEPTH];

    // write port
    // address width covers exactly the depth
    always_ff @(posedge mainclk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // registered read
    // data valid the cycle after rd.en
    // output holds between requests
    always_ff @(posedge mainclk) begin
        if (rd.en) begin
            rd_data <= mem[rd.addr];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/hex_dumper.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "capture_macros.svh"

module hex_dumper (
    input  logic                  mainclk,
    input  logic                  rst,
    input  logic                  dump_start,
    input  capture_pkg::count_t   word_count,
    output capture_pkg::ram_rd_t  rd,
    input  capture_pkg::word_t    rd_data,
    output capture_pkg::ascii_t   tx_data,
    output logic                  tx_valid,
    input  logic                  tx_ready,
    output logic                  dump_done
);
    import capture_pkg::*;

    localparam int NIB_W = $clog2(`CAP_NIBBLES);

    typedef enum logic [2:0] {
        DS_IDLE,
        DS_READ,
        DS_LOAD,
        DS_SEND,
        DS_NEXT
    } dump_st_t;

    dump_st_t         st;
    addr_t            addr_q;
    word_t            word_buf;
    logic [NIB_W-1:0] nib_q;
    logic             send_now;
    logic             last_nib;
    logic             last_word;

    // 0-9 -> "0"-"9", 10-15 -> "a"-"f"
    function automatic ascii_t to_hex(input logic [3:0] n);
        if (n < 4'd10) begin
            return 8'h30 + ascii_t'(n);
        end
        return 8'h57 + ascii_t'(n);
    endfunction

    always_comb begin
        // one strobe per ready window
        send_now  = (st == DS_SEND) && tx_ready && !tx_valid;
        last_nib  = (nib_q == NIB_W'(`CAP_NIBBLES - 1));
        last_word = (count_t'(addr_q) + 1'b1) == word_count;
        rd.en     = (st == DS_READ);
        rd.addr   = addr_q;
    end

    always_ff @(posedge mainclk) begin
        if (rst) begin
            st        <= DS_IDLE;
            addr_q    <= '0;
            nib_q     <= '0;
            tx_valid  <= 1'b0;
            dump_done <= 1'b0;
        end else begin
            tx_valid  <= send_now;
            dump_done <= 1'b0;
            unique case (st)
                DS_IDLE: begin
                    if (dump_start) begin
                        addr_q <= '0;
                        // empty frame, finish right away
                        if (word_count == '0) begin
                            dump_done <= 1'b1;
                        end else begin
                            st <= DS_READ;
                        end
                    end
                end
                DS_READ: begin
                    st <= DS_LOAD;
                end
                DS_LOAD: begin
                    nib_q <= '0;
                    st    <= DS_SEND;
                end
                DS_SEND: begin
                    if (send_now) begin
                        nib_q <= nib_q + 1'b1;
                        if (last_nib) begin
                            st <= DS_NEXT;
                        end
                    end
                end
                DS_NEXT: begin
                    // last char is being taken this cycle
                    if (last_word) begin
                        dump_done <= 1'b1;
                        st        <= DS_IDLE;
                    end else begin
                        addr_q <= addr_q + 1'b1;
                        st     <= DS_READ;
                    end
                end
                default: begin
                    st <= DS_IDLE;
                end
            endcase
        end
    end

    // word buffer, low nibble goes out first
    always_ff @(posedge mainclk) begin
        if (st == DS_LOAD) begin
            word_buf <= rd_data;
        end else if (send_now) begin
            word_buf <= word_buf >> 4;
        end
        if (send_now) begin
            tx_data <= to_hex(word_buf[3:0]);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/nibble_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "capture_macros.svh"

module nibble_packer (
    input  logic                      mainclk,
    input  logic                      rst,
    input  logic                      frame_start,
    input  logic                      rec_en,
    input  logic                      eth_rx_dv,
    input  logic [3:0]                eth_rxd,
    output capture_pkg::ram_wr_t      wr,
    output capture_pkg::count_t       word_count
);
    import capture_pkg::*;

    localparam int NIB_W = $clog2(`CAP_NIBBLES);

    logic [NIB_W-1:0] nib_cnt;
    word_t            shift_q;
    word_t            next_word;
    count_t           count_q;
    logic             wr_en_q;
    addr_t            wr_addr_q;
    word_t            wr_data_q;
    logic             take;
    logic             word_end;

    // swap the two nibbles of every byte
    function automatic word_t pair_flip(input word_t w);
        word_t r;
        for (int b = 0; b < `CAP_WORD_W / 8; b++) begin
            r[8*b +: 4]   = w[8*b+4 +: 4];
            r[8*b+4 +: 4] = w[8*b +: 4];
        end
        return r;
    endfunction

    always_comb begin
        take      = rec_en && eth_rx_dv;
        word_end  = take && (nib_cnt == NIB_W'(`CAP_NIBBLES - 1));
        // new nibble enters from the top, first one ends in 3:0
        next_word = {eth_rxd, shift_q[`CAP_WORD_W-1:4]};
    end

    // nibble position, write strobe and saturating count
    always_ff @(posedge mainclk) begin
        if (rst || frame_start) begin
            nib_cnt <= '0;
            count_q <= '0;
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= 1'b0;
            if (take) begin
                nib_cnt <= nib_cnt + 1'b1;
            end
            // full ram, drop further words
            if (word_end && count_q < `CAP_DEPTH) begin
                wr_en_q <= 1'b1;
                count_q <= count_q + 1'b1;
            end
        end
    end

    // payload side
    always_ff @(posedge mainclk) begin
        if (take) begin
            shift_q <= next_word;
        end
        if (word_end) begin
            // address is the count before the increment
            wr_addr_q <= count_q[`CAP_ADDR_W-1:0];
            wr_data_q <= pair_flip(next_word);
        end
    end

    always_comb begin
        wr.en      = wr_en_q;
        wr.addr    = wr_addr_q;
        wr.data    = wr_data_q;
        word_count = count_q;
    end

endmodule

`default_nettype wire

// ==== hdl/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "capture_macros.svh"

module uart_tx (
    input  logic                 mainclk,
    input  logic                 rst,
    input  capture_pkg::ascii_t  tx_data,
    input  logic                 tx_valid,
    output logic                 tx_ready,
    output logic                 txd
);
    localparam int DIV_W = $clog2(`CAP_BAUD_DIV);

    logic [8:0]       shift_q;
    logic [3:0]       bit_cnt;
    logic [DIV_W-1:0] div_cnt;
    logic             busy;
    logic             accept;
    logic             bit_end;

    always_comb begin
        tx_ready = !busy;
        accept   = tx_valid && !busy;
        bit_end  = (div_cnt == DIV_W'(`CAP_BAUD_DIV - 1));
    end

    // line starts on the start bit, then data lsb first, then stop
    always_ff @(posedge mainclk) begin
        if (rst) begin
            busy    <= 1'b0;
            txd     <= 1'b1;
            div_cnt <= '0;
            bit_cnt <= '0;
        end else if (accept) begin
            busy    <= 1'b1;
            txd     <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
        end else if (busy) begin
            if (bit_end) begin
                div_cnt <= '0;
                if (bit_cnt == 4'd9) begin
                    // stop bit done
                    busy <= 1'b0;
                    txd  <= 1'b1;
                end else begin
                    txd     <= shift_q[0];
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // data and stop bit waiting behind the start bit
    always_ff @(posedge mainclk) begin
        if (accept) begin
            shift_q <= {1'b1, tx_data};
        end else if (busy && bit_end) begin
            shift_q <= shift_q >> 1;
        end
    end

endmodule

`default_nettype wire

// ==== include/capture_macros.svh ====
`ifndef CAPTURE_MACROS_SVH
`define CAPTURE_MACROS_SVH

// frame ram geometry
// one word holds eight received nibbles
`define CAP_WORD_W 32

// nibbles packed into one word
`define CAP_NIBBLES 8

// word address width
`define CAP_ADDR_W 9

// number of stored words, 2**CAP_ADDR_W
`define CAP_DEPTH 512

// uart timing
// mainclk cycles per serial bit
`define CAP_BAUD_DIV 8

`endif

// ==== tb.f ====
+incdir+include
hdl/capture_pkg.sv
hdl/capture_ctrl.sv
hdl/nibble_packer.sv
hdl/frame_ram.sv
hdl/hex_dumper.sv
hdl/uart_tx.sv
hdl/frame_dump_top.sv
verif/frame_dump_asserts.sv
verif/tb_frame_dump.sv

// ==== verif/frame_dump_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "capture_macros.svh"

module frame_dump_asserts (
    input logic                    mainclk,
    input logic                    rst,
    input logic                    uart_txd,
    input capture_pkg::cap_state_t state,
    input logic                    dump_start,
    input logic                    tx_valid,
    input logic                    tx_ready,
    input capture_pkg::ram_wr_t    wr,
    input capture_pkg::count_t     word_count
);
    import capture_pkg::*;

    // count of failed assertions
    int fail_count = 0;

    // stop bit lies 9 bit periods after the byte is taken
    a_stop_bit: assert property (@(posedge mainclk) disable iff (rst)
        (tx_valid && tx_ready) |-> ##(9 * `CAP_BAUD_DIV + 1) uart_txd)
        else begin
            fail_count++;
            $error("uart stop bit was low");
        end

    // strobe only inside a ready window
    a_valid_ready: assert property (@(posedge mainclk) disable iff (rst)
        tx_valid |-> tx_ready)
        else begin
            fail_count++;
            $error("tx_valid high while tx_ready low");
        end

    // dump_start exactly on the cycles that move rec to dump
    a_dump_start: assert property (@(posedge mainclk) disable iff (rst)
        $past(dump_start) == ($past(state) == CAP_REC && state == CAP_DUMP))
        else begin
            fail_count++;
            $error("dump_start outside the rec to dump transition");
        end

    // each write goes to the word just counted and stays below the depth
    a_wr_addr: assert property (@(posedge mainclk) disable iff (rst)
        wr.en |-> (word_count <= `CAP_DEPTH
                   && word_count == count_t'(wr.addr) + 1'b1))
        else begin
            fail_count++;
            $error("ram write address out of range");
        end

endmodule

bind frame_dump_top frame_dump_asserts u_frame_dump_asserts (
    .mainclk    (mainclk),
    .rst        (rst),
    .uart_txd   (uart_txd),
    .state      (state),
    .dump_start (dump_start),
    .tx_valid   (tx_valid),
    .tx_ready   (tx_ready),
    .wr         (wr),
    .word_count (word_count)
);

`default_nettype wire

// ==== verif/tb_frame_dump.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "capture_macros.svh"

module tb_frame_dump;
    import capture_pkg::*;

    localparam int BAUD       = `CAP_BAUD_DIV;
    localparam int HALF       = `CAP_BAUD_DIV / 2;
    // one uart frame plus handshake slack
    localparam int CHAR_LIMIT = 12 * `CAP_BAUD_DIV;

    logic        mainclk;
    logic        rst;
    logic        arm;
    logic        eth_rx_dv;
    logic [3:0]  eth_rxd;
    logic        uart_txd;
    cap_state_t  state;

    // uart decoder
    ascii_t      rx_q [$];
    ascii_t      rx_byte;
    logic        line_busy;
    int          bit_pos;

    logic [31:0] rng;

    frame_dump_top u_frame_dump_top (
        .mainclk   (mainclk),
        .rst       (rst),
        .arm       (arm),
        .eth_rx_dv (eth_rx_dv),
        .eth_rxd   (eth_rxd),
        .uart_txd  (uart_txd),
        .state     (state)
    );

    initial begin
        mainclk = 1'b0;
        forever #2 mainclk = ~mainclk;
    end

    task automatic abort(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "simulation stopped");
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // lowercase hex digit
    function automatic ascii_t hex_char(input logic [3:0] n);
        string digits;
        digits = "0123456789abcdef";
        return ascii_t'(digits[n]);
    endfunction

    task automatic check_state(input string name, input cap_state_t exp, input cap_state_t act);
        if (act !== exp) begin
            abort($sformatf("FAIL %s: expected %s (%0d) actual %s (%0d)",
                            name, exp.name(), exp, act.name(), act));
        end
    endtask

    task automatic check_char(input string name, input ascii_t exp, input ascii_t act);
        if (act !== exp) begin
            abort($sformatf("FAIL %s: expected 8'h%02h actual 8'h%02h", name, exp, act));
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort($sformatf("FAIL %s: expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            abort($sformatf("FAIL %s: expected %0d chars actual %0d chars", name, exp, act));
        end
    endtask

    task automatic wait_state(input string name, input cap_state_t want, input int limit);
        int cycles;
        cycles = 0;
        while (state !== want) begin
            @(negedge mainclk);
            cycles++;
            if (cycles > limit) begin
                abort($sformatf("%s: state never reached %s", name, want.name()));
            end
        end
    endtask

    // line high and decoder idle for more than one frame
    task automatic wait_line_quiet(input string name);
        int quiet;
        int cycles;
        quiet = 0;
        cycles = 0;
        while (quiet < CHAR_LIMIT) begin
            @(negedge mainclk);
            cycles++;
            if (uart_txd === 1'b1 && !line_busy) begin
                quiet++;
            end else begin
                quiet = 0;
            end
            if (cycles > 8 * CHAR_LIMIT) begin
                abort($sformatf("%s: uart line never went quiet", name));
            end
        end
    endtask

    // drive one frame, model its dump and compare
    task automatic run_frame(input string name, input int len);
        logic [3:0] nibs [$];
        ascii_t     exp_q [$];
        int         words;
        int         base;
        rx_q.delete();
        for (int i = 0; i < len; i++) begin
            rng = xorshift32(rng);
            nibs.push_back(rng[3:0]);
            eth_rx_dv = 1'b1;
            eth_rxd = rng[3:0];
            @(negedge mainclk);
            check_state(name, CAP_REC, state);
        end
        eth_rx_dv = 1'b0;
        eth_rxd = 4'h0;
        // first nibble is lost on the idle exit
        // trailing partial word dropped
        words = (len > 0) ? (len - 1) / `CAP_NIBBLES : 0;
        if (words > `CAP_DEPTH) begin
            words = `CAP_DEPTH;
        end
        for (int w = 0; w < words; w++) begin
            base = 1 + w * `CAP_NIBBLES;
            // nibbles of each byte come out swapped
            for (int p = 0; p < `CAP_NIBBLES; p += 2) begin
                exp_q.push_back(hex_char(nibs[base + p + 1]));
                exp_q.push_back(hex_char(nibs[base + p]));
            end
        end
        if (len > 0) begin
            wait_state(name, CAP_DUMP, 4);
            wait_state(name, CAP_IDLE, words * `CAP_NIBBLES * CHAR_LIMIT + 32);
        end
        check_state(name, CAP_IDLE, state);
        wait_line_quiet(name);
        check_count(name, exp_q.size(), rx_q.size());
        foreach (exp_q[i]) begin
            check_char($sformatf("%s char %0d", name, i), exp_q[i], rx_q[i]);
        end
        rng = xorshift32(rng);
        repeat (int'(rng % 32'd5) + 2) @(negedge mainclk);
    endtask

    // mid bit sampling counted from the first low sample
    always @(negedge mainclk) begin
        if (rst) begin
            line_busy <= 1'b0;
            bit_pos   <= 0;
        end else if (!line_busy) begin
            if (uart_txd === 1'b0) begin
                line_busy <= 1'b1;
                bit_pos   <= 1;
            end
        end else begin
            bit_pos <= bit_pos + 1;
            if (bit_pos == HALF && uart_txd !== 1'b0) begin
                abort("uart start bit did not stay low");
            end else if (bit_pos % BAUD == HALF && bit_pos / BAUD >= 1
                         && bit_pos / BAUD <= 8) begin
                rx_byte[bit_pos / BAUD - 1] <= uart_txd;
            end else if (bit_pos == 9 * BAUD + HALF) begin
                if (uart_txd !== 1'b1) begin
                    abort("uart stop bit was low");
                end
                rx_q.push_back(rx_byte);
                line_busy <= 1'b0;
            end
        end
    end

    // bound assertion failures end the run here too
    always @(negedge mainclk) begin
        if (u_frame_dump_top.u_frame_dump_asserts.fail_count != 0) begin
            abort("a bound assertion failed");
        end
    end

    initial begin
        rst = 1'b1;
        arm = 1'b0;
        eth_rx_dv = 1'b0;
        eth_rxd = 4'h0;
        rng = 32'd17;
        repeat (3) @(posedge mainclk);
        @(negedge mainclk);
        rst = 1'b0;
        check_state("reset", CAP_IDLE, state);
        check_level("reset txd", 1'b1, uart_txd);

        // traffic while not armed is ignored
        eth_rx_dv = 1'b1;
        for (int i = 0; i < 20; i++) begin
            rng = xorshift32(rng);
            eth_rxd = rng[3:0];
            @(negedge mainclk);
            check_state("disarmed", CAP_IDLE, state);
            check_level("disarmed txd", 1'b1, uart_txd);
        end
        eth_rx_dv = 1'b0;
        @(negedge mainclk);
        arm = 1'b1;

        // whole words only
        run_frame("whole 9", 9);
        run_frame("whole 25", 25);
        run_frame("whole 65", 65);
        // trailing partial word
        run_frame("partial 14", 14);
        run_frame("partial 31", 31);
        // too short for one word
        run_frame("short 1", 1);
        run_frame("short 5", 5);
        run_frame("short 8", 8);
        // more words than the ram holds
        run_frame("overflow", `CAP_NIBBLES * `CAP_DEPTH + 17);
        // back to back random frames
        for (int f = 0; f < 6; f++) begin
            rng = xorshift32(rng);
            run_frame($sformatf("random %0d", f), int'(rng % 32'd71));
        end

        if (u_frame_dump_top.u_frame_dump_asserts.fail_count == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            abort("a bound assertion failed");
        end
    end

endmodule

`default_nettype wire
